// File: clint_top.f
+incdir+source
source/clint_pkg.sv
source/clint_reg_if.sv
source/axi_lite_reg_bridge.sv
source/clint_regs.sv
source/clint_top.sv
test/clint_tb.sv

// File: Bender.yml
package:
  name: clint

sources:
  - include_dirs:
      - source
    files:
      - source/clint_pkg.sv
      - source/clint_reg_if.sv
      - source/axi_lite_reg_bridge.sv
      - source/clint_regs.sv
      - source/clint_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/clint_tb.sv

// File: test/clint_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "clint_cfg.svh"

module clint_tb;
    import clint_pkg::*;

    logic      clk;
    logic      rst_n;
    axi_addr_t araddr;
    logic      arvalid;
    logic      arready;
    axi_data_t rdata;
    axi_resp_t rresp;
    logic      rvalid;
    logic      rready;
    axi_addr_t awaddr;
    logic      awvalid;
    logic      awready;
    axi_data_t wdata;
    axi_strb_t wstrb;
    logic      wvalid;
    logic      wready;
    axi_resp_t bresp;
    logic      bvalid;
    logic      bready;
    logic      timer_irq;
    logic      soft_irq;

    int     errors = 0;
    // rising edges seen so far
    longint cyc = 0;
    // edge numbers of the last handshakes and of the last write taking effect
    longint last_ar_cyc;
    longint last_r_cyc;
    longint last_wr_edge;

    // register model
    mtime_t model_cmp;
    logic   model_msip;
    // mtime equals mt_base in the cycle after edge mt_edge
    mtime_t mt_base;
    longint mt_edge;

    clint_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .timer_irq (timer_irq),
        .soft_irq  (soft_irq)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] got);
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s expected=%h actual=%h", $time, name, exp, got);
        end
    endtask

    // byte lanes selected by strb come from nw
    function automatic axi_data_t apply_strobe(axi_data_t cur, axi_data_t nw, axi_strb_t strb);
        axi_data_t mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (cur & ~mask) | (nw & mask);
    endfunction

    // model timer value in the cycle after edge c
    function automatic mtime_t model_mtime(longint c);
        return mt_base + mtime_t'(c - mt_edge);
    endfunction

    function automatic reg_off_t unmapped_off();
        reg_off_t o;
        o = reg_off_t'($urandom);
        if (o == `CLINT_MSIP_OFF || o == `CLINT_MTIMECMP_LO_OFF ||
            o == `CLINT_MTIMECMP_HI_OFF || o == `CLINT_MTIME_LO_OFF ||
            o == `CLINT_MTIME_HI_OFF) begin
            // moves every mapped offset off the map
            o = o ^ 16'h0100;
        end
        return o;
    endfunction

    task automatic axi_read(input reg_off_t off, output axi_data_t data, output axi_resp_t resp);
        axi_addr_t addr;
        int        n;
        addr = $urandom;
        addr[15:0] = off;
        data = '0;
        resp = 2'b11;
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        n = 0;
        while (!arready && n < 64) begin
            @(negedge clk);
            n++;
        end
        if (!arready) begin
            errors++;
            $display("timeout: arready never came for offset %h", off);
            arvalid = 1'b0;
            return;
        end
        // handshake on the coming edge
        last_ar_cyc = cyc + 1;
        @(negedge clk);
        arvalid = 1'b0;
        rready  = ($urandom % 4) != 0;
        n = 0;
        while (!(rvalid && rready) && n < 64) begin
            @(negedge clk);
            rready = ($urandom % 4) != 0;
            n++;
        end
        if (!(rvalid && rready)) begin
            errors++;
            $display("timeout: no read response for offset %h", off);
            rready = 1'b0;
            return;
        end
        last_r_cyc = cyc + 1;
        data = rdata;
        resp = rresp;
        @(negedge clk);
        rready = 1'b0;
        // response delivered exactly once
        if (rvalid !== 1'b0) begin
            errors++;
            $display("rvalid stayed high after the read response was taken");
        end
    endtask

    task automatic axi_write(input reg_off_t off, input axi_data_t data, input axi_strb_t strb,
                             output axi_resp_t resp);
        axi_addr_t addr;
        int        n;
        addr = $urandom;
        addr[15:0] = off;
        resp = 2'b11;
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        n = 0;
        while (!(awready && wready) && n < 64) begin
            @(negedge clk);
            n++;
        end
        if (!(awready && wready)) begin
            errors++;
            $display("timeout: awready and wready never came for offset %h", off);
            awvalid = 1'b0;
            wvalid  = 1'b0;
            return;
        end
        // register access one cycle after the handshake
        last_wr_edge = cyc + 2;
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = ($urandom % 4) != 0;
        n = 0;
        while (!(bvalid && bready) && n < 64) begin
            @(negedge clk);
            bready = ($urandom % 4) != 0;
            n++;
        end
        if (!(bvalid && bready)) begin
            errors++;
            $display("timeout: no write response for offset %h", off);
            bready = 1'b0;
            return;
        end
        resp = bresp;
        @(negedge clk);
        bready = 1'b0;
        if (bvalid !== 1'b0) begin
            errors++;
            $display("bvalid stayed high after the write response was taken");
        end
    endtask

    // msip and both compare halves against the model
    task automatic verify_regs();
        axi_data_t rd;
        axi_resp_t resp;
        axi_read(`CLINT_MSIP_OFF, rd, resp);
        check_val("rresp", RESP_OKAY, resp);
        check_val("msip", {63'd0, model_msip}, rd);
        axi_read(`CLINT_MTIMECMP_LO_OFF, rd, resp);
        check_val("rresp", RESP_OKAY, resp);
        check_val("mtimecmp_lo", model_cmp[31:0], rd);
        axi_read(`CLINT_MTIMECMP_HI_OFF, rd, resp);
        check_val("rresp", RESP_OKAY, resp);
        check_val("mtimecmp_hi", model_cmp[63:32], rd);
    endtask

    // mtime low must lie between the model values at the AR and R handshakes
    task automatic read_mtime_lo(output axi_data_t rd);
        axi_resp_t resp;
        mtime_t    lo_bound;
        mtime_t    hi_bound;
        axi_read(`CLINT_MTIME_LO_OFF, rd, resp);
        check_val("rresp", RESP_OKAY, resp);
        lo_bound = model_mtime(last_ar_cyc);
        hi_bound = model_mtime(last_r_cyc);
        if (rd < lo_bound[31:0] || rd > hi_bound[31:0]) begin
            errors++;
            $display("FAIL t=%0t mtime_lo expected=%h..%h actual=%h",
                     $time, lo_bound[31:0], hi_bound[31:0], rd);
        end
    endtask

    task automatic write_cmp(input mtime_t val);
        axi_resp_t resp;
        // high half first
        axi_write(`CLINT_MTIMECMP_HI_OFF, val[63:32], 4'hf, resp);
        check_val("bresp", RESP_OKAY, resp);
        axi_write(`CLINT_MTIMECMP_LO_OFF, val[31:0], 4'hf, resp);
        check_val("bresp", RESP_OKAY, resp);
        model_cmp = val;
    endtask

    initial begin
        axi_data_t rd;
        axi_data_t rd2;
        axi_data_t wd;
        axi_strb_t ws;
        axi_resp_t resp;
        reg_off_t  off;
        mtime_t    target;
        mtime_t    m;
        int        n;

        void'($urandom(32'h2e69cf33));
        rst_n   = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        model_cmp  = '1;
        model_msip = 1'b0;
        mt_base = '0;
        mt_edge = 0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        // state after reset
        check_val("rvalid", 1'b0, rvalid);
        check_val("bvalid", 1'b0, bvalid);
        check_val("timer_irq", 1'b0, timer_irq);
        check_val("soft_irq", 1'b0, soft_irq);
        check_val("arready", 1'b1, arready);
        check_val("awready", 1'b1, awready);
        check_val("wready", 1'b1, wready);
        verify_regs();

        // random strobed writes to msip and compare
        for (int i = 0; i < 24; i++) begin
            wd = $urandom;
            ws = axi_strb_t'($urandom);
            case ($urandom % 3)
                0: off = `CLINT_MSIP_OFF;
                1: off = `CLINT_MTIMECMP_LO_OFF;
                default: off = `CLINT_MTIMECMP_HI_OFF;
            endcase
            axi_write(off, wd, ws, resp);
            check_val("bresp", RESP_OKAY, resp);
            if (off == `CLINT_MSIP_OFF && ws[0]) begin
                model_msip = wd[0];
            end else if (off == `CLINT_MTIMECMP_LO_OFF) begin
                model_cmp[31:0] = apply_strobe(model_cmp[31:0], wd, ws);
            end else if (off == `CLINT_MTIMECMP_HI_OFF) begin
                model_cmp[63:32] = apply_strobe(model_cmp[63:32], wd, ws);
            end
            check_val("soft_irq", model_msip, soft_irq);
            verify_regs();
        end

        // clear high half so the low write sets the whole timer
        axi_write(`CLINT_MTIME_HI_OFF, '0, 4'hf, resp);
        check_val("bresp", RESP_OKAY, resp);
        wd = $urandom & 32'h7fff_ffff;
        axi_write(`CLINT_MTIME_LO_OFF, wd, 4'hf, resp);
        check_val("bresp", RESP_OKAY, resp);
        mt_base = {32'd0, wd};
        mt_edge = last_wr_edge;
        read_mtime_lo(rd);
        read_mtime_lo(rd2);
        if (rd2 < rd) begin
            errors++;
            $display("FAIL t=%0t mtime_lo expected>=%h actual=%h", $time, rd, rd2);
        end

        // unmapped offsets
        for (int i = 0; i < 8; i++) begin
            axi_read(unmapped_off(), rd, resp);
            check_val("rresp", RESP_SLVERR, resp);
            axi_write(unmapped_off(), $urandom, axi_strb_t'($urandom), resp);
            check_val("bresp", RESP_SLVERR, resp);
        end
        verify_regs();
        read_mtime_lo(rd);
        axi_read(`CLINT_MTIME_HI_OFF, rd, resp);
        check_val("rresp", RESP_OKAY, resp);
        m = model_mtime(last_r_cyc);
        check_val("mtime_hi", m[63:32], rd);

        // timer irq a few hundred cycles ahead
        target = model_mtime(cyc) + 64'd300;
        write_cmp(target);
        n = 0;
        m = model_mtime(cyc);
        while (m <= target + 64'd8 && n < 1000) begin
            if (m + 64'd4 < target && timer_irq !== 1'b0) begin
                errors++;
                $display("FAIL t=%0t timer_irq expected=0 actual=%b", $time, timer_irq);
            end
            if (m > target + 64'd4 && timer_irq !== 1'b1) begin
                errors++;
                $display("FAIL t=%0t timer_irq expected=1 actual=%b", $time, timer_irq);
            end
            @(negedge clk);
            n++;
            m = model_mtime(cyc);
        end
        if (m <= target + 64'd8) begin
            errors++;
            $display("timeout: model timer never passed the compare value");
        end
        check_val("timer_irq", 1'b1, timer_irq);
        write_cmp('1);
        check_val("timer_irq", 1'b0, timer_irq);
        verify_regs();

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/clint_top.sv
`timescale 1ns/1ps
`default_nettype none

module clint_top (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    // AR
    input  wire clint_pkg::axi_addr_t araddr,
    input  wire logic                 arvalid,
    output logic                      arready,
    // R
    output clint_pkg::axi_data_t      rdata,
    output clint_pkg::axi_resp_t      rresp,
    output logic                      rvalid,
    input  wire logic                 rready,
    // AW
    input  wire clint_pkg::axi_addr_t awaddr,
    input  wire logic                 awvalid,
    output logic                      awready,
    // W
    input  wire clint_pkg::axi_data_t wdata,
    input  wire clint_pkg::axi_strb_t wstrb,
    input  wire logic                 wvalid,
    output logic                      wready,
    // B
    output clint_pkg::axi_resp_t      bresp,
    output logic                      bvalid,
    input  wire logic                 bready,
    // interrupt lines to the hart
    output logic                      timer_irq,
    output logic                      soft_irq
);

    // bridge to register block
    clint_reg_if reg_bus ();

    axi_lite_reg_bridge u_bridge (
        .clk     (clk),
        .rst_n   (rst_n),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .reg_bus (reg_bus.bridge)
    );

    clint_regs u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .reg_bus   (reg_bus.regs),
        .timer_irq (timer_irq),
        .soft_irq  (soft_irq)
    );

endmodule

`default_nettype wire

// File: source/clint_regs.sv
`timescale 1ns/1ps
`default_nettype none

module clint_regs (
    input  wire logic clk,
    input  wire logic rst_n,
    clint_reg_if.regs reg_bus,
    output logic      timer_irq,
    output logic      soft_irq
);
    import clint_pkg::*;
    `include "clint_cfg.svh"

    mtime_t mtime;
    mtime_t mtimecmp;
    logic   msip;

    // offset decode
    logic sel_msip;
    logic sel_cmp_lo;
    logic sel_cmp_hi;
    logic sel_mtime_lo;
    logic sel_mtime_hi;
    logic wr;

    // byte lanes of nw replace old where strb is set
    function automatic axi_data_t merge_bytes(
        input axi_data_t old,
        input axi_data_t nw,
        input axi_strb_t strb
    );
        axi_data_t res;
        res = old;
        for (int i = 0; i < $bits(axi_strb_t); i++) begin
            if (strb[i]) begin
                res[i*8 +: 8] = nw[i*8 +: 8];
            end
        end
        return res;
    endfunction

    assign sel_msip     = (reg_bus.off == `CLINT_MSIP_OFF);
    assign sel_cmp_lo   = (reg_bus.off == `CLINT_MTIMECMP_LO_OFF);
    assign sel_cmp_hi   = (reg_bus.off == `CLINT_MTIMECMP_HI_OFF);
    assign sel_mtime_lo = (reg_bus.off == `CLINT_MTIME_LO_OFF);
    assign sel_mtime_hi = (reg_bus.off == `CLINT_MTIME_HI_OFF);

    // nothing matched
    assign reg_bus.err = !(sel_msip || sel_cmp_lo || sel_cmp_hi ||
                           sel_mtime_lo || sel_mtime_hi);

    assign wr = reg_bus.req && reg_bus.we && !reg_bus.err;

    // same cycle read mux
    always_comb begin
        reg_bus.rdata = '0;
        if (sel_msip) begin
            // only bit 0 exists
            reg_bus.rdata = {{($bits(axi_data_t) - 1){1'b0}}, msip};
        end else if (sel_cmp_lo) begin
            reg_bus.rdata = mtimecmp[31:0];
        end else if (sel_cmp_hi) begin
            reg_bus.rdata = mtimecmp[63:32];
        end else if (sel_mtime_lo) begin
            reg_bus.rdata = mtime[31:0];
        end else if (sel_mtime_hi) begin
            reg_bus.rdata = mtime[63:32];
        end
    end

    // free running timer
    // a write replaces the increment
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtime <= '0;
        end else if (wr && sel_mtime_lo) begin
            mtime[31:0] <= merge_bytes(mtime[31:0], reg_bus.wdata, reg_bus.strb);
        end else if (wr && sel_mtime_hi) begin
            mtime[63:32] <= merge_bytes(mtime[63:32], reg_bus.wdata, reg_bus.strb);
        end else begin
            mtime <= mtime + 64'd1;
        end
    end

    // compare value and software irq bit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtimecmp <= '1;
            msip     <= 1'b0;
        end else if (wr) begin
            if (sel_cmp_lo) begin
                mtimecmp[31:0] <= merge_bytes(mtimecmp[31:0], reg_bus.wdata, reg_bus.strb);
            end
            if (sel_cmp_hi) begin
                mtimecmp[63:32] <= merge_bytes(mtimecmp[63:32], reg_bus.wdata, reg_bus.strb);
            end
            // lane 0 carries the only stored bit
            if (sel_msip && reg_bus.strb[0]) begin
                msip <= reg_bus.wdata[0];
            end
        end
    end

    // irq outputs lag the state by one cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            timer_irq <= 1'b0;
            soft_irq  <= 1'b0;
        end else begin
            timer_irq <= (mtime >= mtimecmp);
            soft_irq  <= msip;
        end
    end

    // timer still below compare after its next tick keeps the irq low
    a_no_early_irq: assert property (@(posedge clk) disable iff (!rst_n)
        !wr && (mtime + 64'd1 < mtimecmp) |-> ##2 !timer_irq);

    // unmapped access leaves every register alone
    a_unmapped_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        reg_bus.req && reg_bus.err |=>
            $stable(mtimecmp) && $stable(msip) && (mtime == $past(mtime) + 64'd1));

endmodule

`default_nettype wire

// File: source/axi_lite_reg_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module axi_lite_reg_bridge (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    // AR
    input  wire clint_pkg::axi_addr_t araddr,
    input  wire logic                 arvalid,
    output logic                      arready,
    // R
    output clint_pkg::axi_data_t      rdata,
    output clint_pkg::axi_resp_t      rresp,
    output logic                      rvalid,
    input  wire logic                 rready,
    // AW
    input  wire clint_pkg::axi_addr_t awaddr,
    input  wire logic                 awvalid,
    output logic                      awready,
    // W
    input  wire clint_pkg::axi_data_t wdata,
    input  wire clint_pkg::axi_strb_t wstrb,
    input  wire logic                 wvalid,
    output logic                      wready,
    // B
    output clint_pkg::axi_resp_t      bresp,
    output logic                      bvalid,
    input  wire logic                 bready,
    // register side
    clint_reg_if.bridge               reg_bus
);
    import clint_pkg::*;
    `include "clint_cfg.svh"

    // lfsr and wait counter share one width
    localparam int WAIT_W = $clog2(`BRIDGE_MAX_WAIT + 1);

    bridge_state_t     state;
    logic [WAIT_W-1:0] lfsr;
    logic [WAIT_W-1:0] wait_cnt;
    // write access still to be issued in WR_RESP
    logic              wr_issue;

    // captured request payload
    reg_off_t  addr_q;
    axi_data_t wdata_q;
    axi_strb_t strb_q;

    logic ar_fire;
    logic wr_fire;
    logic rd_hit;

    // read side always ready in IDLE
    assign arready = (state == IDLE);
    // aw and w go together, never one alone
    // a pending read blocks the write
    assign awready = (state == IDLE) && !arvalid && !(awvalid ^ wvalid);
    assign wready  = awready;

    assign ar_fire = arvalid && arready;
    assign wr_fire = awvalid && wvalid && awready;

    // wait over, issue the read this cycle
    assign rd_hit = (state == RD_WAIT) && (wait_cnt == lfsr);

    assign reg_bus.req   = rd_hit || ((state == WR_RESP) && wr_issue);
    assign reg_bus.we    = (state == WR_RESP);
    assign reg_bus.off   = addr_q;
    assign reg_bus.wdata = wdata_q;
    assign reg_bus.strb  = strb_q;

    // control state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= IDLE;
            lfsr     <= `LFSR_SEED;
            wait_cnt <= '0;
            wr_issue <= 1'b0;
            rvalid   <= 1'b0;
            bvalid   <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    // new pseudo-random delay every idle cycle
                    lfsr     <= {lfsr[WAIT_W-2:0], lfsr[WAIT_W-1] ^ lfsr[WAIT_W-2]};
                    wait_cnt <= '0;
                    if (ar_fire) begin
                        state <= RD_WAIT;
                    end else if (wr_fire) begin
                        state    <= WR_RESP;
                        wr_issue <= 1'b1;
                    end
                end
                RD_WAIT: begin
                    if (rd_hit) begin
                        state    <= RD_RESP;
                        rvalid   <= 1'b1;
                        wait_cnt <= '0;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                RD_RESP: begin
                    // hold until the master takes it
                    if (rready) begin
                        state  <= IDLE;
                        rvalid <= 1'b0;
                    end
                end
                WR_RESP: begin
                    if (wr_issue) begin
                        wr_issue <= 1'b0;
                        bvalid   <= 1'b1;
                    end else if (bready) begin
                        state  <= IDLE;
                        bvalid <= 1'b0;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // request payload, captured on handshake
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            addr_q <= araddr[15:0];
        end else if (wr_fire) begin
            addr_q  <= awaddr[15:0];
            wdata_q <= wdata;
            strb_q  <= wstrb;
        end
    end

    // response payload, sampled with the register access
    always_ff @(posedge clk) begin
        if (rd_hit) begin
            rdata <= reg_bus.rdata;
            rresp <= reg_bus.err ? RESP_SLVERR : RESP_OKAY;
        end
        if ((state == WR_RESP) && wr_issue) begin
            bresp <= reg_bus.err ? RESP_SLVERR : RESP_OKAY;
        end
    end

    // read response held under back-pressure
    a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata));

    // write response held under back-pressure
    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid);

    // one access per transaction, one cycle long
    a_req_single: assert property (@(posedge clk) disable iff (!rst_n)
        reg_bus.req |=> !reg_bus.req);

endmodule

`default_nettype wire

// File: source/clint_reg_if.sv
`timescale 1ns/1ps
`default_nettype none

interface clint_reg_if;
    import clint_pkg::*;

    // single cycle access strobe
    logic      req;
    logic      we;
    reg_off_t  off;
    axi_data_t wdata;
    axi_strb_t strb;
    // combinational answer from the register block
    axi_data_t rdata;
    logic      err;

    modport bridge (
        output req, we, off, wdata, strb,
        input  rdata, err
    );

    modport regs (
        input  req, we, off, wdata, strb,
        output rdata, err
    );

endinterface

`default_nettype wire

// File: source/clint_pkg.sv
`default_nettype none

package clint_pkg;

    `include "clint_cfg.svh"

    // bus payload types
    typedef logic [`AXI_ADDR_W-1:0]   axi_addr_t;
    typedef logic [`AXI_DATA_W-1:0]   axi_data_t;
    typedef logic [`AXI_DATA_W/8-1:0] axi_strb_t;
    typedef logic [1:0]               axi_resp_t;

    // register offset, low address bits
    typedef logic [15:0] reg_off_t;
    // full timer width
    typedef logic [63:0] mtime_t;

    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

    // bridge fsm
    typedef enum logic [1:0] {
        IDLE,
        RD_WAIT,
        RD_RESP,
        WR_RESP
    } bridge_state_t;

endpackage

`default_nettype wire

// File: source/clint_cfg.svh
`ifndef CLINT_CFG_SVH
`define CLINT_CFG_SVH

// axi-lite bus widths
`define AXI_ADDR_W 32
`define AXI_DATA_W 32

// register map, low 16 address bits
`define CLINT_MSIP_OFF        16'h0000
`define CLINT_MTIMECMP_LO_OFF 16'h4000
`define CLINT_MTIMECMP_HI_OFF 16'h4004
`define CLINT_MTIME_LO_OFF    16'hbff8
`define CLINT_MTIME_HI_OFF    16'hbffc

// bridge read latency lfsr
`define LFSR_SEED 3'b001
// longest read wait in cycles, also sets lfsr width
`define BRIDGE_MAX_WAIT 7

`endif
